// ==== verilog/walk_cfg.svh ====
// Page walker configuration macros

`ifndef WALK_CFG_SVH
`define WALK_CFG_SVH

// ------------------------------------------------------------
// Bus and address width
// ------------------------------------------------------------
`define WALK_ADDR_W            32

// Translation base, upper bits only (16 KB aligned table)
`define WALK_TTB_BASE_HI       31
`define WALK_TTB_BASE_LO       14

// Virtual address fields
`define WALK_VA_L1_IDX_HI      31
`define WALK_VA_L1_IDX_LO      20
`define WALK_VA_L2_IDX_HI      19
`define WALK_VA_L2_IDX_LO      12

// ------------------------------------------------------------
// Descriptor fields
// ------------------------------------------------------------
`define WALK_COARSE_BASE_LO    10
`define WALK_DOMAIN_HI         8
`define WALK_DOMAIN_LO         5
`define WALK_SECTION_AP_HI     11
`define WALK_SECTION_AP_LO     10
`define WALK_PAGE_AP_HI        5
`define WALK_PAGE_AP_LO        4
`define WALK_CB_HI             3
`define WALK_CB_LO             2
`define WALK_SECTION_BASE_LO   20
`define WALK_SPAGE_BASE_LO     12
`define WALK_LPAGE_BASE_LO     16

`endif

// ==== verilog/walk_pkg.sv ====
// Page walker types

`include "walk_cfg.svh"

package walk_pkg;

    // ------------------------------------------------------------
    // Descriptor type field
    // ------------------------------------------------------------
    typedef logic [1:0] desc_kind_t;

    // Shared by both levels
    localparam desc_kind_t KIND_FAULT  = 2'b00;
    // Level 1 encodings
    localparam desc_kind_t L1_COARSE   = 2'b01;
    localparam desc_kind_t L1_SECTION  = 2'b10;
    localparam desc_kind_t L1_RESERVED = 2'b11;
    // Level 2 encodings
    localparam desc_kind_t L2_LPAGE    = 2'b01;
    localparam desc_kind_t L2_SPAGE    = 2'b10;
    localparam desc_kind_t L2_TINY     = 2'b11;

    // Field widths, derived from the descriptor layout
    localparam int SECTION_W = `WALK_ADDR_W - `WALK_SECTION_BASE_LO;
    localparam int SPAGE_W   = `WALK_ADDR_W - `WALK_SPAGE_BASE_LO;
    localparam int LPAGE_W   = `WALK_ADDR_W - `WALK_LPAGE_BASE_LO;
    localparam int DOMAIN_W  = `WALK_DOMAIN_HI - `WALK_DOMAIN_LO + 1;

    // ------------------------------------------------------------
    // TLB entries
    // ------------------------------------------------------------
    typedef struct packed {
        logic [SECTION_W-1:0] tag;
        logic [SECTION_W-1:0] base;
        logic [DOMAIN_W-1:0]  domain;
        logic [1:0]           ap;
        logic [1:0]           cb;
        desc_kind_t           kind;
    } section_entry_t;

    typedef struct packed {
        logic [SPAGE_W-1:0]   tag;
        logic [SPAGE_W-1:0]   base;
        logic [DOMAIN_W-1:0]  domain;
        logic [1:0]           ap;
        logic [1:0]           cb;
        desc_kind_t           kind;
    } spage_entry_t;

    typedef struct packed {
        logic [LPAGE_W-1:0]   tag;
        logic [LPAGE_W-1:0]   base;
        logic [DOMAIN_W-1:0]  domain;
        logic [1:0]           ap;
        logic [1:0]           cb;
        desc_kind_t           kind;
    } lpage_entry_t;

    // Walk FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_L1_FETCH,
        ST_L2_FETCH,
        ST_WRITE,
        ST_DONE
    } walk_state_t;

endpackage

// ==== verilog/desc_fetch.sv ====
// Descriptor bus read engine

`include "walk_cfg.svh"

module desc_fetch (
    input  logic                    i_clk,
    input  logic                    i_reset,

    // ------------------------------------------------------------
    // Fetch request from walk FSM
    // ------------------------------------------------------------
    input  logic                    i_start,
    input  logic [`WALK_ADDR_W-1:0] i_addr,
    output logic                    o_done,
    output logic [`WALK_ADDR_W-1:0] o_desc,

    // ------------------------------------------------------------
    // Wishbone read port
    // ------------------------------------------------------------
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic [`WALK_ADDR_W-1:0] o_wb_adr,
    input  logic [`WALK_ADDR_W-1:0] i_wb_dat,
    input  logic                    i_wb_ack,
    input  logic                    i_wb_err
);

    // Cycle in progress, drives both cyc and stb
    logic                    busy_q;
    logic                    done_q;
    logic [`WALK_ADDR_W-1:0] adr_q;
    logic [`WALK_ADDR_W-1:0] desc_q;
    // Bus cycle ends this clock
    logic                    term;

    assign term = busy_q && (i_wb_ack || i_wb_err);

    // Control state
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            // Done is a single pulse
            done_q <= term;
            if (i_start)
            begin
                busy_q <= 1'b1;
            end
            else if (term)
            begin
                busy_q <= 1'b0;
            end
        end
    end

    // Address and captured descriptor
    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            adr_q <= i_addr;
        end
        // Error clears type bits, so the word decodes as a fault
        if (term)
        begin
            desc_q <= {i_wb_dat[`WALK_ADDR_W-1:2], i_wb_err ? 2'b00 : i_wb_dat[1:0]};
        end
    end

    assign o_wb_cyc = busy_q;
    assign o_wb_stb = busy_q;
    assign o_wb_adr = adr_q;
    assign o_done   = done_q;
    assign o_desc   = desc_q;

endmodule

// ==== verilog/entry_format.sv ====
// TLB entry formatter

`include "walk_cfg.svh"

module entry_format
    import walk_pkg::*;
(
    // ------------------------------------------------------------
    // Descriptor and walk context
    // ------------------------------------------------------------
    input  logic [`WALK_ADDR_W-1:0]                   i_desc,
    input  logic [`WALK_ADDR_W-1:0]                   i_va,
    input  logic [`WALK_DOMAIN_HI-`WALK_DOMAIN_LO:0]  i_domain,
    input  logic                                      i_level2,

    // ------------------------------------------------------------
    // Decoded kind and TLB entries
    // ------------------------------------------------------------
    output desc_kind_t                                o_desc_kind,
    output section_entry_t                            o_section_entry,
    output spage_entry_t                              o_spage_entry,
    output lpage_entry_t                              o_lpage_entry
);

    desc_kind_t raw_kind;

    assign raw_kind = desc_kind_t'(i_desc[1:0]);

    // Kind decode, unsupported types fold into fault
    always_comb
    begin
        if (i_level2)
        begin
            case (raw_kind)
                L2_LPAGE : o_desc_kind = L2_LPAGE;
                L2_SPAGE : o_desc_kind = L2_SPAGE;
                // Tiny pages need fine tables
                L2_TINY  : o_desc_kind = KIND_FAULT;
                default  : o_desc_kind = KIND_FAULT;
            endcase
        end
        else
        begin
            case (raw_kind)
                L1_COARSE   : o_desc_kind = L1_COARSE;
                L1_SECTION  : o_desc_kind = L1_SECTION;
                L1_RESERVED : o_desc_kind = KIND_FAULT;
                default     : o_desc_kind = KIND_FAULT;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Section entry, domain taken from the descriptor itself
    // ------------------------------------------------------------
    assign o_section_entry.tag    = i_va[`WALK_ADDR_W-1:`WALK_SECTION_BASE_LO];
    assign o_section_entry.base   = i_desc[`WALK_ADDR_W-1:`WALK_SECTION_BASE_LO];
    assign o_section_entry.domain = i_desc[`WALK_DOMAIN_HI:`WALK_DOMAIN_LO];
    assign o_section_entry.ap     = i_desc[`WALK_SECTION_AP_HI:`WALK_SECTION_AP_LO];
    assign o_section_entry.cb     = i_desc[`WALK_CB_HI:`WALK_CB_LO];
    assign o_section_entry.kind   = o_desc_kind;

    // ------------------------------------------------------------
    // Page entries, domain kept from the coarse L1 descriptor
    // ------------------------------------------------------------
    assign o_spage_entry.tag      = i_va[`WALK_ADDR_W-1:`WALK_SPAGE_BASE_LO];
    assign o_spage_entry.base     = i_desc[`WALK_ADDR_W-1:`WALK_SPAGE_BASE_LO];
    assign o_spage_entry.domain   = i_domain;
    assign o_spage_entry.ap       = i_desc[`WALK_PAGE_AP_HI:`WALK_PAGE_AP_LO];
    assign o_spage_entry.cb       = i_desc[`WALK_CB_HI:`WALK_CB_LO];
    assign o_spage_entry.kind     = o_desc_kind;

    // 64 KB page, 16-bit tag and base
    assign o_lpage_entry.tag      = i_va[`WALK_ADDR_W-1:`WALK_LPAGE_BASE_LO];
    assign o_lpage_entry.base     = i_desc[`WALK_ADDR_W-1:`WALK_LPAGE_BASE_LO];
    assign o_lpage_entry.domain   = i_domain;
    assign o_lpage_entry.ap       = i_desc[`WALK_PAGE_AP_HI:`WALK_PAGE_AP_LO];
    assign o_lpage_entry.cb       = i_desc[`WALK_CB_HI:`WALK_CB_LO];
    assign o_lpage_entry.kind     = o_desc_kind;

endmodule

// ==== verilog/walk_ctrl.sv ====
// Page walk FSM

`include "walk_cfg.svh"

module walk_ctrl
    import walk_pkg::*;
(
    input  logic                                      i_clk,
    input  logic                                      i_reset,

    // ------------------------------------------------------------
    // Requester handshake
    // ------------------------------------------------------------
    input  logic                                      i_walk_req,
    input  logic [`WALK_ADDR_W-1:0]                   i_walk_va,
    input  logic [`WALK_ADDR_W-1:0]                   i_ttb,
    output logic                                      o_walk_ack,

    // ------------------------------------------------------------
    // Fetch engine
    // ------------------------------------------------------------
    output logic                                      o_start_fetch,
    output logic [`WALK_ADDR_W-1:0]                   o_fetch_addr,
    input  logic                                      i_fetch_done,
    input  logic [`WALK_ADDR_W-1:0]                   i_desc,
    input  desc_kind_t                                i_desc_kind,

    // ------------------------------------------------------------
    // Formatter context and TLB writes
    // ------------------------------------------------------------
    output logic [`WALK_ADDR_W-1:0]                   o_va,
    output logic [`WALK_DOMAIN_HI-`WALK_DOMAIN_LO:0]  o_domain,
    output logic                                      o_level2,
    output logic                                      o_section_wen,
    output logic                                      o_spage_wen,
    output logic                                      o_lpage_wen
);

    walk_state_t                              state_q;
    walk_state_t                              state_nxt;
    logic                                     level2_q;
    logic [`WALK_ADDR_W-1:0]                  va_q;
    logic [`WALK_DOMAIN_HI-`WALK_DOMAIN_LO:0] domain_q;
    logic [`WALK_ADDR_W-1:0]                  l1_addr;
    logic [`WALK_ADDR_W-1:0]                  l2_addr;
    // Walk accepted this cycle
    logic                                     walk_start;
    // L1 coarse descriptor arrived
    logic                                     go_l2;

    // Table addresses, word aligned
    assign l1_addr = {i_ttb[`WALK_TTB_BASE_HI:`WALK_TTB_BASE_LO],
                      i_walk_va[`WALK_VA_L1_IDX_HI:`WALK_VA_L1_IDX_LO], 2'b00};
    assign l2_addr = {i_desc[`WALK_ADDR_W-1:`WALK_COARSE_BASE_LO],
                      va_q[`WALK_VA_L2_IDX_HI:`WALK_VA_L2_IDX_LO], 2'b00};

    assign walk_start = (state_q == ST_IDLE) && i_walk_req;
    assign go_l2      = (state_q == ST_L1_FETCH) && i_fetch_done && (i_desc_kind == L1_COARSE);

    // Start pulses go out in the same cycle as the decision
    assign o_start_fetch = walk_start || go_l2;
    assign o_fetch_addr  = (state_q == ST_IDLE) ? l1_addr : l2_addr;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (i_walk_req)
                begin
                    state_nxt = ST_L1_FETCH;
                end
            end
            ST_L1_FETCH:
            begin
                if (i_fetch_done)
                begin
                    state_nxt = go_l2 ? ST_L2_FETCH : ST_WRITE;
                end
            end
            ST_L2_FETCH:
            begin
                if (i_fetch_done)
                begin
                    state_nxt = ST_WRITE;
                end
            end
            // One write cycle, then ack
            ST_WRITE: state_nxt = ST_DONE;
            ST_DONE:
            begin
                // Hold ack until requester lets go
                if (!i_walk_req)
                begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state_q  <= ST_IDLE;
            level2_q <= 1'b0;
        end
        else
        begin
            state_q <= state_nxt;
            if (walk_start)
            begin
                level2_q <= 1'b0;
            end
            else if (go_l2)
            begin
                level2_q <= 1'b1;
            end
        end
    end

    // Walk context
    always_ff @(posedge i_clk)
    begin
        if (walk_start)
        begin
            va_q <= i_walk_va;
        end
        if (go_l2)
        begin
            domain_q <= i_desc[`WALK_DOMAIN_HI:`WALK_DOMAIN_LO];
        end
    end

    // ------------------------------------------------------------
    // TLB select, desc is held so entries stay stable
    // ------------------------------------------------------------
    assign o_section_wen = (state_q == ST_WRITE) && !level2_q;
    assign o_lpage_wen   = (state_q == ST_WRITE) && level2_q && (i_desc_kind == L2_LPAGE);
    assign o_spage_wen   = (state_q == ST_WRITE) && level2_q && (i_desc_kind != L2_LPAGE);

    assign o_walk_ack = (state_q == ST_DONE);
    assign o_va       = va_q;
    assign o_domain   = domain_q;
    assign o_level2   = level2_q;

endmodule

// ==== verilog/page_walker.sv ====
// Page table walker top level

`include "walk_cfg.svh"

module page_walker
    import walk_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,

    // ------------------------------------------------------------
    // Requester
    // ------------------------------------------------------------
    input  logic                    i_walk_req,
    input  logic [`WALK_ADDR_W-1:0] i_walk_va,
    input  logic [`WALK_ADDR_W-1:0] i_ttb,
    output logic                    o_walk_ack,

    // ------------------------------------------------------------
    // Wishbone read port
    // ------------------------------------------------------------
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic [`WALK_ADDR_W-1:0] o_wb_adr,
    input  logic [`WALK_ADDR_W-1:0] i_wb_dat,
    input  logic                    i_wb_ack,
    input  logic                    i_wb_err,

    // ------------------------------------------------------------
    // TLB write ports
    // ------------------------------------------------------------
    output logic                    o_section_wen,
    output section_entry_t          o_section_entry,
    output logic                    o_spage_wen,
    output spage_entry_t            o_spage_entry,
    output logic                    o_lpage_wen,
    output lpage_entry_t            o_lpage_entry
);

    logic                                     start_fetch;
    logic [`WALK_ADDR_W-1:0]                  fetch_addr;
    logic                                     fetch_done;
    logic [`WALK_ADDR_W-1:0]                  desc;
    desc_kind_t                               desc_kind;
    logic [`WALK_ADDR_W-1:0]                  walk_va;
    logic [`WALK_DOMAIN_HI-`WALK_DOMAIN_LO:0] walk_domain;
    logic                                     level2;

    // Bus reads
    desc_fetch u_fetch (
        .i_clk    (i_clk),       .i_reset  (i_reset),
        .i_start  (start_fetch), .i_addr   (fetch_addr),
        .o_done   (fetch_done),  .o_desc   (desc),
        .o_wb_cyc (o_wb_cyc),    .o_wb_stb (o_wb_stb),
        .o_wb_adr (o_wb_adr),    .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack),    .i_wb_err (i_wb_err)
    );

    // Entry packing
    entry_format u_format (
        .i_desc          (desc),            .i_va            (walk_va),
        .i_domain        (walk_domain),     .i_level2        (level2),
        .o_desc_kind     (desc_kind),       .o_section_entry (o_section_entry),
        .o_spage_entry   (o_spage_entry),   .o_lpage_entry   (o_lpage_entry)
    );

    // Sequencing and handshake
    walk_ctrl u_ctrl (
        .i_clk         (i_clk),         .i_reset       (i_reset),
        .i_walk_req    (i_walk_req),    .i_walk_va     (i_walk_va),
        .i_ttb         (i_ttb),         .o_walk_ack    (o_walk_ack),
        .o_start_fetch (start_fetch),   .o_fetch_addr  (fetch_addr),
        .i_fetch_done  (fetch_done),    .i_desc        (desc),
        .i_desc_kind   (desc_kind),     .o_va          (walk_va),
        .o_domain      (walk_domain),   .o_level2      (level2),
        .o_section_wen (o_section_wen), .o_spage_wen   (o_spage_wen),
        .o_lpage_wen   (o_lpage_wen)
    );

endmodule

// ==== test/page_walker_checker.sv ====
// Page walker protocol checker

module page_walker_checker (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_walk_req,
    input  logic i_walk_ack,
    input  logic i_wb_cyc,
    input  logic i_wb_stb,
    input  logic i_wb_ack,
    input  logic i_wb_err,
    input  logic i_section_wen,
    input  logic i_spage_wen,
    input  logic i_lpage_wen
);

    logic any_wen;

    assign any_wen = i_section_wen || i_spage_wen || i_lpage_wen;

    // ------------------------------------------------------------
    // TLB writes and requester handshake
    // ------------------------------------------------------------
    assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0({i_section_wen, i_spage_wen, i_lpage_wen}))
        else $error("More than one TLB write enable high in one cycle");

    // Ack follows the single write pulse
    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_walk_ack) |-> $past(any_wen))
        else $error("Walk ack rose without a write pulse in the cycle before");

    // Release only once req was seen low
    assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(i_walk_ack) |-> $past(!i_walk_req))
        else $error("Walk ack fell while req was still high");

    // ------------------------------------------------------------
    // Wishbone side
    // ------------------------------------------------------------
    assert property (@(posedge i_clk) disable iff (i_reset) i_wb_cyc == i_wb_stb)
        else $error("Bus cyc and stb differ");

    // Stb waits for ack or err
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wb_stb && !i_wb_ack && !i_wb_err) |=> i_wb_stb)
        else $error("Bus stb dropped before ack or err");

    // No bus traffic while a finished walk is held
    assert property (@(posedge i_clk) disable iff (i_reset) i_walk_ack |-> !i_wb_cyc)
        else $error("Bus cycle while walk ack is high");

endmodule

bind page_walker page_walker_checker checker_i (
    .i_clk         (i_clk),         .i_reset       (i_reset),
    .i_walk_req    (i_walk_req),    .i_walk_ack    (o_walk_ack),
    .i_wb_cyc      (o_wb_cyc),      .i_wb_stb      (o_wb_stb),
    .i_wb_ack      (i_wb_ack),      .i_wb_err      (i_wb_err),
    .i_section_wen (o_section_wen), .i_spage_wen   (o_spage_wen),
    .i_lpage_wen   (o_lpage_wen)
);

// ==== test/page_walker_tb.sv ====
// Page walker testbench

`include "walk_cfg.svh"

module page_walker_tb
    import walk_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DLY    = 2;
    localparam int NUM_ROWS     = 8;
    localparam int MAX_WAIT     = 3;
    localparam int HOLD_CYCLES  = 2;
    localparam int ACK_LIMIT    = 24;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;
    localparam logic [1:0] SEL_SECTION = 2'd0;
    localparam logic [1:0] SEL_SPAGE   = 2'd1;
    localparam logic [1:0] SEL_LPAGE   = 2'd2;

    // One walk with inputs, memory words, error flags per level and expected TLB write
    typedef struct packed {
        logic [31:0] va;
        logic [31:0] ttb;
        logic [31:0] l1;
        logic [31:0] l2;
        logic [1:0]  err;
        logic [1:0]  sel;
        logic [19:0] base;
        logic [3:0]  domain;
        logic [1:0]  ap;
        logic [1:0]  cb;
        logic [1:0]  kind;
    } walk_row_t;

    logic clk = 1'b0;
    logic reset;
    logic walk_req, walk_ack;
    logic [31:0] walk_va, ttb;
    logic wb_cyc, wb_stb, wb_ack, wb_err;
    logic [31:0] wb_adr, wb_dat;
    logic sec_wen, sp_wen, lp_wen;
    section_entry_t sec_entry, sec_got;
    spage_entry_t sp_entry, sp_got;
    lpage_entry_t lp_entry, lp_got;

    walk_row_t rows [NUM_ROWS];
    walk_row_t cur_row;
    bit walk_active = 1'b0;
    int reads_in_walk, wen_count;
    logic [1:0] got_sel;
    int mismatch_count = 0;
    int other_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    page_walker dut_i (
        .i_clk (clk), .i_reset (reset),
        .i_walk_req (walk_req), .i_walk_va (walk_va), .i_ttb (ttb), .o_walk_ack (walk_ack),
        .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_adr (wb_adr),
        .i_wb_dat (wb_dat), .i_wb_ack (wb_ack), .i_wb_err (wb_err),
        .o_section_wen (sec_wen), .o_section_entry (sec_entry),
        .o_spage_wen (sp_wen), .o_spage_entry (sp_entry),
        .o_lpage_wen (lp_wen), .o_lpage_entry (lp_entry)
    );

    // ------------------------------------------------------------
    // Expected bus addresses and read counts
    // ------------------------------------------------------------
    function automatic logic [31:0] l1_address(input walk_row_t row);
        return {row.ttb[`WALK_TTB_BASE_HI:`WALK_TTB_BASE_LO],
                row.va[`WALK_VA_L1_IDX_HI:`WALK_VA_L1_IDX_LO], 2'b00};
    endfunction

    function automatic logic [31:0] l2_address(input walk_row_t row);
        return {row.l1[`WALK_ADDR_W-1:`WALK_COARSE_BASE_LO],
                row.va[`WALK_VA_L2_IDX_HI:`WALK_VA_L2_IDX_LO], 2'b00};
    endfunction

    // Coarse L1 without bus error needs the second read
    function automatic int expected_reads(input walk_row_t row);
        return (row.l1[1:0] == 2'b01 && !row.err[0]) ? 2 : 1;
    endfunction

    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            mismatch_count++;
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_count++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    task automatic load_table();
        // Section, then coarse with small and large pages
        rows[0] = '{32'h1234_5678, 32'h0004_0000, 32'hABC0_0CAA, 32'h0, 2'b00,
                    SEL_SECTION, 20'h00ABC, 4'h5, 2'h3, 2'h2, 2'h2};
        rows[1] = '{32'h8765_4321, 32'h0010_C000, 32'h0020_0541, 32'hFEDC_B01E, 2'b00,
                    SEL_SPAGE, 20'hFEDCB, 4'hA, 2'h1, 2'h3, 2'h2};
        rows[2] = '{32'h4000_F000, 32'h0004_0000, 32'h0030_0061, 32'h1357_0025, 2'b00,
                    SEL_LPAGE, 20'h01357, 4'h3, 2'h2, 2'h1, 2'h1};
        // Bus errors at L1 and L2
        rows[3] = '{32'h0010_0000, 32'h0004_0000, 32'hABC0_0CAA, 32'h0, 2'b01,
                    SEL_SECTION, 20'h00ABC, 4'h5, 2'h3, 2'h2, 2'h0};
        // Faulted large page lands in the small page TLB
        rows[4] = '{32'h4000_F000, 32'h0004_0000, 32'h0030_0061, 32'h1357_0025, 2'b10,
                    SEL_SPAGE, 20'h13570, 4'h3, 2'h2, 2'h1, 2'h0};
        // Fault, reserved L1 and tiny L2 types
        rows[5] = '{32'hFFF0_0000, 32'h0004_0000, 32'hABC0_0CA8, 32'h0, 2'b00,
                    SEL_SECTION, 20'h00ABC, 4'h5, 2'h3, 2'h2, 2'h0};
        rows[6] = '{32'h0000_0000, 32'h0004_0000, 32'hABC0_0CAB, 32'h0, 2'b00,
                    SEL_SECTION, 20'h00ABC, 4'h5, 2'h3, 2'h2, 2'h0};
        rows[7] = '{32'h8765_4321, 32'h0010_C000, 32'h0020_0541, 32'hFEDC_B01F, 2'b00,
                    SEL_SPAGE, 20'hFEDCB, 4'hA, 2'h1, 2'h3, 2'h0};
    endtask

    // ------------------------------------------------------------
    // Bus memory model
    // ------------------------------------------------------------
    task automatic accept_read();
        logic [31:0] exp_adr;
        assert (walk_active && reads_in_walk < expected_reads(cur_row))
        else report_failure($sformatf("unexpected bus read at address %h", wb_adr));
        exp_adr = (reads_in_walk == 0) ? l1_address(cur_row) : l2_address(cur_row);
        compare_field("bus address", wb_adr, exp_adr);
        reads_in_walk++;
    endtask

    task automatic answer_read();
        bit last_l1;
        last_l1 = (reads_in_walk <= 1);
        wb_dat = last_l1 ? cur_row.l1 : cur_row.l2;
        // Err replaces ack for this level
        if (last_l1 ? cur_row.err[0] : cur_row.err[1])
            wb_err = 1'b1;
        else
            wb_ack = 1'b1;
    endtask

    initial
    begin
        int unsigned wait_cnt;
        bit in_cycle;
        void'($urandom(32'h5e5cf9c9));
        wb_ack = 1'b0;
        wb_err = 1'b0;
        wb_dat = '0;
        in_cycle = 1'b0;
        wait_cnt = 0;
        forever
        begin
            @(posedge clk);
            #DRIVE_DLY;
            wb_ack = 1'b0;
            wb_err = 1'b0;
            if (wb_stb)
            begin
                if (!in_cycle)
                begin
                    in_cycle = 1'b1;
                    wait_cnt = $urandom % (MAX_WAIT + 1);
                    accept_read();
                end
                if (wait_cnt == 0)
                begin
                    answer_read();
                    in_cycle = 1'b0;
                end
                else
                begin
                    wait_cnt--;
                end
            end
        end
    end

    // TLB write monitor samples mid cycle
    always @(negedge clk)
    begin
        if (!reset && (sec_wen || sp_wen || lp_wen))
        begin
            assert (walk_active) else report_failure("TLB write enable high outside a walk");
            wen_count++;
            got_sel = sec_wen ? SEL_SECTION : (sp_wen ? SEL_SPAGE : SEL_LPAGE);
            sec_got = sec_entry;
            sp_got  = sp_entry;
            lp_got  = lp_entry;
        end
    end

    // ------------------------------------------------------------
    // Requester and result checks
    // ------------------------------------------------------------
    task automatic wait_for_ack(input logic level, output bit seen);
        int n;
        n = 0;
        while (walk_ack !== level && n < ACK_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end
        seen = (walk_ack === level);
    endtask

    task automatic check_walk(input int idx, input walk_row_t row);
        assert (wen_count == 1)
        else report_failure($sformatf("walk %0d gave %0d TLB writes", idx, wen_count));
        compare_field("bus read count", reads_in_walk, expected_reads(row));
        compare_field("TLB select", got_sel, row.sel);
        case (row.sel)
            SEL_SECTION:
            begin
                compare_field("section tag", sec_got.tag, row.va[31:20]);
                compare_field("section base", sec_got.base, row.base);
                compare_field("section domain", sec_got.domain, row.domain);
                compare_field("section ap", sec_got.ap, row.ap);
                compare_field("section cb", sec_got.cb, row.cb);
                compare_field("section kind", sec_got.kind, row.kind);
            end
            SEL_SPAGE:
            begin
                compare_field("small page tag", sp_got.tag, row.va[31:12]);
                compare_field("small page base", sp_got.base, row.base);
                compare_field("small page domain", sp_got.domain, row.domain);
                compare_field("small page ap", sp_got.ap, row.ap);
                compare_field("small page cb", sp_got.cb, row.cb);
                compare_field("small page kind", sp_got.kind, row.kind);
            end
            default:
            begin
                compare_field("large page tag", lp_got.tag, row.va[31:16]);
                compare_field("large page base", lp_got.base, row.base);
                compare_field("large page domain", lp_got.domain, row.domain);
                compare_field("large page ap", lp_got.ap, row.ap);
                compare_field("large page cb", lp_got.cb, row.cb);
                compare_field("large page kind", lp_got.kind, row.kind);
            end
        endcase
    endtask

    task automatic run_walk(input int idx);
        bit seen;
        cur_row = rows[idx];
        reads_in_walk = 0;
        wen_count = 0;
        got_sel = 2'd3;
        walk_active = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        walk_va = cur_row.va;
        ttb = cur_row.ttb;
        walk_req = 1'b1;
        wait_for_ack(1'b1, seen);
        assert (seen) else report_failure($sformatf("walk %0d never raised ack", idx));
        // Held req blocks new work and keeps ack high
        repeat (HOLD_CYCLES)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            assert (walk_ack) else report_failure("ack dropped while req was held");
        end
        check_walk(idx, cur_row);
        // Walk is over once its entry is checked
        walk_active = 1'b0;
        walk_req = 1'b0;
        wait_for_ack(1'b0, seen);
        assert (seen) else report_failure($sformatf("walk %0d never dropped ack", idx));
    endtask

    initial
    begin
        reset = 1'b1;
        walk_req = 1'b0;
        walk_va = '0;
        ttb = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            run_walk(i);
        end
        // Idle tail where any write is flagged
        repeat (3) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all walks finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== page_walker.f ====
+incdir+verilog
verilog/walk_pkg.sv
verilog/desc_fetch.sv
verilog/entry_format.sv
verilog/walk_ctrl.sv
verilog/page_walker.sv
test/page_walker_checker.sv
test/page_walker_tb.sv
